// ==== design/op_sequencer.sv ====
// operator sequencer
// holds the register file and key-on flags, and on each accepted sample strobe
// sweeps the slots and broadcasts every slot's settings to all banks

`timescale 1ns/1ps
`default_nettype none

`include "opl_defines.svh"

module op_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_wr,        // single cycle write strobe
    input  opl_pkg::reg_write_t cfg,
    input  logic                sample_en,     // single cycle sample strobe
    output logic                slot_valid,
    output opl_pkg::slot_cmd_t  slot_cmd
);
    import opl_pkg::*;

    localparam int NB = `OPL_NUM_BANKS;
    localparam int NS = `OPL_OPS_PER_BANK;

    slot_cfg_t regs [NB][NS];                      // register file, one entry per bank and slot
    logic      key_on_flag [NB][NS];               // pending restart, sent with the next sweep

    logic      busy;                               // a sweep is running
    slot_idx_t slot_cnt;                           // next slot to issue while busy
    logic      start;                              // strobe accepted this cycle
    logic      issue;                              // a slot goes out on this edge
    slot_idx_t issue_slot;

    always_comb begin
        start      = sample_en && !busy;           // strobes during a sweep are dropped
        issue      = start || busy;
        issue_slot = busy ? slot_cnt : '0;         // slot 0 leaves on the accepting edge
    end

    // sweep control and the registered valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            slot_cnt   <= '0;
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= issue;
            if (start) begin
                busy     <= (NS > 1);              // a single slot sweep ends at once
                slot_cnt <= slot_idx_t'(1);
            end else if (busy) begin
                slot_cnt <= slot_cnt + 1'b1;
                if (slot_cnt == slot_idx_t'(NS - 1)) begin
                    busy <= 1'b0;                  // last slot has just been issued
                end
            end
        end
    end

    // register file and key-on flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < NB; b++) begin
                for (int s = 0; s < NS; s++) begin
                    regs[b][s]        <= '0;
                    key_on_flag[b][s] <= 1'b0;
                end
            end
        end else begin
            if (issue) begin
                for (int b = 0; b < NB; b++) begin
                    key_on_flag[b][issue_slot] <= 1'b0;   // flag is consumed as it is sent
                end
            end
            if (cfg_wr) begin
                regs[cfg.bank][cfg.slot] <= '{
                    phase_inc: cfg.phase_inc,
                    wave:      cfg.wave,
                    env_shift: cfg.env_shift,
                    fb:        cfg.fb
                };
                if (cfg.key_on) begin
                    key_on_flag[cfg.bank][cfg.slot] <= 1'b1;  // a new key-on beats the clear
                end
            end
        end
    end

    // settings of the slot issued on this edge, packed for every bank
    always_ff @(posedge clk) begin
        if (issue) begin
            slot_cmd.slot <= issue_slot;
            for (int b = 0; b < NB; b++) begin
                slot_cmd.bank[b]         <= regs[b][issue_slot];
                slot_cmd.key_on_pulse[b] <= key_on_flag[b][issue_slot];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/operator_bank.sv ====
// operator bank
// per-slot phase accumulators with self-feedback, quarter-sine waveform
// shaping and shift attenuation, two cycles from slot_valid to out_valid

`timescale 1ns/1ps
`default_nettype none

`include "opl_defines.svh"

module operator_bank #(
    parameter int BANK_INDEX = 0                   // which fields of slot_cmd belong to this bank
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               slot_valid,
    input  opl_pkg::slot_cmd_t slot_cmd,
    output logic               out_valid,
    output opl_pkg::bank_out_t bank_out
);
    import opl_pkg::*;

    localparam int  NS        = `OPL_OPS_PER_BANK;
    localparam int  PHASE_W   = `OPL_PHASE_W;
    localparam int  OUT_W     = `OPL_OUT_W;
    localparam int  IDX_W     = 8;                 // quarter wave index below the two quadrant bits
    localparam int  ROM_DEPTH = 1 << IDX_W;
    localparam int  ROM_W     = $clog2(`OPL_SINE_MAX + 1);
    localparam int  SAW_W     = 11;                // saw ramps over the top 11 phase bits
    localparam real PI        = 3.14159265358979;

    localparam logic signed [OUT_W-1:0] WAVE_MAX = `OPL_SINE_MAX;

    // samples sit at the middle of each step so the table never hits zero
    function automatic logic [ROM_DEPTH-1:0][ROM_W-1:0] build_sine_rom();
        logic [ROM_DEPTH-1:0][ROM_W-1:0] rom;
        real                             angle;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            angle  = (i + 0.5) * PI / (2.0 * ROM_DEPTH);
            rom[i] = ROM_W'($rtoi(`OPL_SINE_MAX * $sin(angle) + 0.5));
        end
        return rom;
    endfunction

    localparam logic [ROM_DEPTH-1:0][ROM_W-1:0] SINE_ROM = build_sine_rom();

    // full sine from a quarter table, bit 18 mirrors and bit 19 negates
    function automatic logic signed [OUT_W-1:0] sine_lookup(input phase_t ph);
        logic [IDX_W-1:0]        idx;
        logic signed [OUT_W-1:0] mag;
        idx = ph[PHASE_W-3 -: IDX_W];
        if (ph[PHASE_W-2]) begin
            idx = ~idx;
        end
        mag = OUT_W'(SINE_ROM[idx]);
        return ph[PHASE_W-1] ? -mag : mag;
    endfunction

    function automatic logic signed [OUT_W-1:0] abs_val(input logic signed [OUT_W-1:0] v);
        return (v < 0) ? -v : v;
    endfunction

    phase_t                  phase_acc [NS];       // accumulated phase, no modulation
    logic signed [OUT_W-1:0] fb_mem [NS];          // last output of each slot

    slot_cfg_t               cfg;                  // this bank's share of the command
    logic                    key_pulse;
    phase_t                  acc_next;
    logic signed [PHASE_W-1:0] fb_ext;             // feedback sign extended to phase width
    phase_t                  fb_term;

    logic                    s1_valid;             // stage 1 holds the final phase
    phase_t                  s1_phase;
    wave_sel_e               s1_wave;
    env_t                    s1_env;
    slot_idx_t               s1_slot;

    phase_t                  alt_phase;
    logic signed [OUT_W-1:0] sine_val;
    logic signed [OUT_W-1:0] alt_val;
    logic signed [OUT_W-1:0] saw_val;
    logic signed [OUT_W-1:0] shaped;
    logic signed [OUT_W-1:0] atten;

    always_comb begin
        cfg       = slot_cmd.bank[BANK_INDEX];
        key_pulse = slot_cmd.key_on_pulse[BANK_INDEX];
        acc_next  = phase_acc[slot_cmd.slot] + cfg.phase_inc;   // wraps at phase width
        fb_ext    = fb_mem[slot_cmd.slot];
        fb_term   = (cfg.fb == '0) ? '0 : phase_t'(fb_ext <<< (2 + cfg.fb));
    end

    // stage 1 updates the accumulator and forms the modulated phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            for (int s = 0; s < NS; s++) begin
                phase_acc[s] <= '0;
                fb_mem[s]    <= '0;
            end
        end else begin
            s1_valid <= slot_valid;
            if (s1_valid) begin
                fb_mem[s1_slot] <= atten;          // becomes the modulator next sweep
            end
            if (slot_valid) begin
                if (key_pulse) begin
                    phase_acc[slot_cmd.slot] <= '0;
                    fb_mem[slot_cmd.slot]    <= '0;
                end else begin
                    phase_acc[slot_cmd.slot] <= acc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_valid) begin
            s1_phase <= key_pulse ? '0 : acc_next + fb_term;
            s1_wave  <= cfg.wave;
            s1_env   <= cfg.env_shift;
            s1_slot  <= slot_cmd.slot;
        end
    end

    // stage 2 shapes the phase into the selected waveform
    always_comb begin
        alt_phase = s1_phase << 1;                 // double speed for the alternating waves
        sine_val  = sine_lookup(s1_phase);
        alt_val   = s1_phase[PHASE_W-1] ? '0 : sine_lookup(alt_phase);
        saw_val   = OUT_W'(s1_phase[PHASE_W-1 -: SAW_W]) - OUT_W'(1 << (SAW_W - 1));
        case (s1_wave)
            SINE:         shaped = sine_val;
            HALF_SINE:    shaped = (sine_val < 0) ? '0 : sine_val;
            ABS_SINE:     shaped = abs_val(sine_val);
            QUARTER_SINE: shaped = s1_phase[PHASE_W-2] ? '0 : abs_val(sine_val);
            ALT_SINE:     shaped = alt_val;
            ALT_ABS_SINE: shaped = abs_val(alt_val);
            SQUARE:       shaped = s1_phase[PHASE_W-1] ? -WAVE_MAX : WAVE_MAX;
            SAW:          shaped = saw_val;
        endcase
        atten = shaped >>> s1_env;                 // envelope stands in as a plain shift
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            bank_out.op_out <= atten;
        end
    end

endmodule

`default_nettype wire

// ==== design/opl_core.sv ====
// opl operator core top level
// sequencer feeding a row of identical operator banks, summed by the mixer
// sample_valid follows an accepted sample_en by slots per bank plus 3 cycles

`timescale 1ns/1ps
`default_nettype none

`include "opl_defines.svh"

module opl_core (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cfg_wr,
    input  opl_pkg::reg_write_t             cfg,
    input  logic                            sample_en,
    output logic                            sample_valid,
    output logic signed [`OPL_SAMPLE_W-1:0] sample
);
    import opl_pkg::*;

    localparam int NB = `OPL_NUM_BANKS;

    logic      slot_valid;                         // broadcast to every bank
    slot_cmd_t slot_cmd;
    logic      bank_valid [NB];
    bank_out_t bank_out [NB];

    op_sequencer op_sequencer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg        (cfg),
        .sample_en  (sample_en),
        .slot_valid (slot_valid),
        .slot_cmd   (slot_cmd)
    );

    for (genvar b = 0; b < NB; b++) begin : g_bank
        operator_bank #(
            .BANK_INDEX (b)
        ) operator_bank_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .slot_valid (slot_valid),
            .slot_cmd   (slot_cmd),
            .out_valid  (bank_valid[b]),
            .bank_out   (bank_out[b])
        );
    end

    sample_mixer sample_mixer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .out_valid    (bank_valid),
        .bank_out     (bank_out),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

endmodule

`default_nettype wire

// ==== design/opl_defines.svh ====
// opl operator core parameters
// bank and slot counts plus the datapath widths shared by every block

`ifndef OPL_DEFINES_SVH
`define OPL_DEFINES_SVH

// number of identical operator banks
`define OPL_NUM_BANKS 2

// operator slots swept per bank on every sample
`define OPL_OPS_PER_BANK 4

// datapath widths
`define OPL_PHASE_W 20
`define OPL_OUT_W 13
`define OPL_SAMPLE_W 16
`define OPL_ENV_W 4
`define OPL_FB_W 3

// peak of the quarter-sine table, also the square wave level
`define OPL_SINE_MAX 2047

`endif

// ==== design/opl_pkg.sv ====
// opl operator core types
// register write, per-sample slot broadcast and bank result structs

`default_nettype none

`include "opl_defines.svh"

package opl_pkg;

    typedef logic [$clog2(`OPL_NUM_BANKS)-1:0]    bank_idx_t;   // selects one bank
    typedef logic [$clog2(`OPL_OPS_PER_BANK)-1:0] slot_idx_t;   // selects one slot in a bank
    typedef logic [`OPL_PHASE_W-1:0]              phase_t;      // accumulator and increment
    typedef logic [`OPL_ENV_W-1:0]                env_t;        // right shift applied to output
    typedef logic [`OPL_FB_W-1:0]                 fb_t;         // zero turns feedback off

    // waveform select, encoded as in the OPL3 ws register
    typedef enum logic [2:0] {
        SINE         = 3'd0,
        HALF_SINE    = 3'd1,
        ABS_SINE     = 3'd2,
        QUARTER_SINE = 3'd3,
        ALT_SINE     = 3'd4,
        ALT_ABS_SINE = 3'd5,
        SQUARE       = 3'd6,
        SAW          = 3'd7
    } wave_sel_e;

    // settings of one slot as held in the register file
    typedef struct packed {
        phase_t    phase_inc;
        wave_sel_e wave;
        env_t      env_shift;
        fb_t       fb;
    } slot_cfg_t;

    // one host write into the register file
    typedef struct packed {
        bank_idx_t bank;
        slot_idx_t slot;
        phase_t    phase_inc;
        wave_sel_e wave;
        env_t      env_shift;
        fb_t       fb;
        logic      key_on;          // restart this slot on the next sweep
    } reg_write_t;

    // one step of the sweep, broadcast to every bank at once
    typedef struct packed {
        slot_idx_t                         slot;
        logic [`OPL_NUM_BANKS-1:0]         key_on_pulse;   // one bit for each bank
        slot_cfg_t [`OPL_NUM_BANKS-1:0]    bank;           // bank b reads bank[b]
    } slot_cmd_t;

    // result of one slot in one bank
    typedef struct packed {
        logic signed [`OPL_OUT_W-1:0] op_out;
    } bank_out_t;

endpackage

`default_nettype wire

// ==== design/sample_mixer.sv ====
// sample mixer
// adds every bank output over one sweep and saturates the total to a sample

`timescale 1ns/1ps
`default_nettype none

`include "opl_defines.svh"

module sample_mixer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            out_valid [`OPL_NUM_BANKS],
    input  opl_pkg::bank_out_t              bank_out [`OPL_NUM_BANKS],
    output logic                            sample_valid,
    output logic signed [`OPL_SAMPLE_W-1:0] sample
);
    import opl_pkg::*;

    localparam int NB       = `OPL_NUM_BANKS;
    localparam int NS       = `OPL_OPS_PER_BANK;
    localparam int SAMPLE_W = `OPL_SAMPLE_W;
    localparam int ACC_W    = SAMPLE_W + $clog2(NB * NS) + 1;   // headroom for every operator

    localparam logic signed [ACC_W-1:0] SAT_MAX = (2 ** (SAMPLE_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (SAMPLE_W - 1));

    logic signed [ACC_W-1:0] acc;                  // running sum of the current sweep
    slot_idx_t               slot_cnt;             // slots already summed
    logic                    any_valid;
    logic signed [ACC_W-1:0] step_sum;             // contribution of this cycle
    logic signed [ACC_W-1:0] total;
    logic signed [SAMPLE_W-1:0] sat;

    always_comb begin
        any_valid = 1'b0;
        step_sum  = '0;
        for (int b = 0; b < NB; b++) begin
            if (out_valid[b]) begin
                step_sum  = step_sum + ACC_W'(bank_out[b].op_out);
                any_valid = 1'b1;
            end
        end
        total = acc + step_sum;
        if (total > SAT_MAX) begin
            sat = SAT_MAX[SAMPLE_W-1:0];
        end else if (total < SAT_MIN) begin
            sat = SAT_MIN[SAMPLE_W-1:0];
        end else begin
            sat = total[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            slot_cnt     <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (any_valid) begin
                if (slot_cnt == slot_idx_t'(NS - 1)) begin
                    acc          <= '0;            // ready for the next sweep
                    slot_cnt     <= '0;
                    sample_valid <= 1'b1;
                end else begin
                    acc      <= total;
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_valid && slot_cnt == slot_idx_t'(NS - 1)) begin
            sample <= sat;
        end
    end

endmodule

`default_nettype wire

// ==== opl_core.f ====
+incdir+design
+incdir+test
design/opl_pkg.sv
design/op_sequencer.sv
design/operator_bank.sv
design/sample_mixer.sv
design/opl_core.sv
test/opl_core_tb.sv

// ==== test/opl_ref_model.svh ====
// reference model of the opl operator core
// per-slot phase and feedback state with the waveform, shift and saturation rules

`ifndef OPL_REF_MODEL_SVH
`define OPL_REF_MODEL_SVH

localparam int PH_MASK  = (1 << `OPL_PHASE_W) - 1;
localparam int SINE_MAX = `OPL_SINE_MAX;

int         sine_table [256];                             // quarter wave, sampled mid step
int         acc_m [`OPL_NUM_BANKS][`OPL_OPS_PER_BANK];    // accumulated phase per slot
int         fb_m [`OPL_NUM_BANKS][`OPL_OPS_PER_BANK];     // last output of each slot
reg_write_t regs_m [`OPL_NUM_BANKS][`OPL_OPS_PER_BANK];
bit         key_m [`OPL_NUM_BANKS][`OPL_OPS_PER_BANK];    // restart owed to the next sweep

function automatic void init_model();
    for (int i = 0; i < 256; i++) begin
        sine_table[i] = $rtoi(SINE_MAX * $sin((i + 0.5) * 3.14159265358979 / 512.0) + 0.5);
    end
    for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
        for (int s = 0; s < `OPL_OPS_PER_BANK; s++) begin
            acc_m[b][s]  = 0;
            fb_m[b][s]   = 0;
            regs_m[b][s] = '0;
            key_m[b][s]  = 1'b0;
        end
    end
endfunction

// bits 17:10 index the quarter wave, bit 18 mirrors it and bit 19 flips the sign
function automatic int sine_value(input int ph);
    int idx;
    idx = (ph >> 10) & 255;
    if (ph[18]) begin
        idx = 255 - idx;
    end
    return ph[19] ? -sine_table[idx] : sine_table[idx];
endfunction

function automatic int shape_wave(input wave_sel_e wave, input int ph);
    int s;
    int alt;
    s   = sine_value(ph);
    alt = ph[19] ? 0 : sine_value((ph << 1) & PH_MASK);   // double speed, silent second half
    case (wave)
        SINE:         return s;
        HALF_SINE:    return (s < 0) ? 0 : s;
        ABS_SINE:     return (s < 0) ? -s : s;
        QUARTER_SINE: return ph[18] ? 0 : ((s < 0) ? -s : s);
        ALT_SINE:     return alt;
        ALT_ABS_SINE: return (alt < 0) ? -alt : alt;
        SQUARE:       return ph[19] ? -SINE_MAX : SINE_MAX;
        default:      return (ph >> 9) - 1024;             // saw over the top 11 phase bits
    endcase
endfunction

function automatic int attenuate(input int v, input int shift);
    return v >>> shift;
endfunction

function automatic logic signed [`OPL_SAMPLE_W-1:0] saturate(input int v);
    int hi;
    hi = (1 << (`OPL_SAMPLE_W - 1)) - 1;
    if (v > hi) begin
        return `OPL_SAMPLE_W'(hi);
    end
    if (v < -hi - 1) begin
        return `OPL_SAMPLE_W'(-hi - 1);
    end
    return `OPL_SAMPLE_W'(v);
endfunction

function automatic void note_write(input reg_write_t w);
    regs_m[w.bank][w.slot] = w;
    if (w.key_on) begin
        key_m[w.bank][w.slot] = 1'b1;                     // only a sweep clears it
    end
endfunction

// one full sweep over every slot of every bank, returns the mixed sample
function automatic logic signed [`OPL_SAMPLE_W-1:0] sweep_model();
    int sum;
    int ph;
    int out;
    sum = 0;
    for (int s = 0; s < `OPL_OPS_PER_BANK; s++) begin
        for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
            if (key_m[b][s]) begin
                acc_m[b][s] = 0;
                key_m[b][s] = 1'b0;
                ph          = 0;                           // restarted slot plays phase zero
            end else begin
                acc_m[b][s] = (acc_m[b][s] + int'(regs_m[b][s].phase_inc)) & PH_MASK;
                ph          = acc_m[b][s];
                if (regs_m[b][s].fb != 0) begin
                    ph = (ph + (fb_m[b][s] << (2 + regs_m[b][s].fb))) & PH_MASK;
                end
            end
            out        = attenuate(shape_wave(regs_m[b][s].wave, ph),
                                   int'(regs_m[b][s].env_shift));
            fb_m[b][s] = out;
            sum       += out;
        end
    end
    return saturate(sum);
endfunction

`endif

// ==== test/opl_core_tb.sv ====
// testbench for the opl operator core
// replays a table of register writes and sample requests against a reference model

`timescale 1ns/1ps
`default_nettype none

`include "opl_defines.svh"

module opl_core_tb;
    import opl_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int LATENCY    = `OPL_OPS_PER_BANK + 3;    // accepted strobe to sample_valid
    localparam int QUIET      = 3;                        // covers a strobe taken mid-sweep

    typedef struct packed {
        logic                            is_sample;
        logic                            extra_strobe;    // pulse sample_en again mid-sweep
        reg_write_t                      wr;
        logic signed [`OPL_SAMPLE_W-1:0] expected;
    } row_t;

    logic                            clk;
    logic                            rst_n;
    logic                            cfg_wr;
    reg_write_t                      cfg;
    logic                            sample_en;
    logic                            sample_valid;
    logic signed [`OPL_SAMPLE_W-1:0] sample;

    row_t   rows [$];
    integer seed = 51204;
    bit     table_built;

    `include "opl_ref_model.svh"

    opl_core opl_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg          (cfg),
        .sample_en    (sample_en),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_sample(input logic signed [`OPL_SAMPLE_W-1:0] actual,
                                input logic signed [`OPL_SAMPLE_W-1:0] expected,
                                input string what);
        if (actual !== expected) begin
            fail_now($sformatf("%s is %0d, expected %0d", what, actual, expected));
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            fail_now($sformatf("%s is %0d, expected %0d", what, actual, expected));
        end
    endtask

    function automatic void add_write(input int bank, input int slot, input int inc,
                                      input wave_sel_e wave, input int env, input int fb,
                                      input bit key_on);
        row_t r;
        r              = '0;
        r.wr.bank      = bank_idx_t'(bank);
        r.wr.slot      = slot_idx_t'(slot);
        r.wr.phase_inc = phase_t'(inc);
        r.wr.wave      = wave;
        r.wr.env_shift = env_t'(env);
        r.wr.fb        = fb_t'(fb);
        r.wr.key_on    = key_on;
        note_write(r.wr);
        rows.push_back(r);
    endfunction

    function automatic void add_sample(input bit extra);
        row_t r;
        r              = '0;
        r.is_sample    = 1'b1;
        r.extra_strobe = extra;
        r.expected     = sweep_model();                   // model steps in table order
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        init_model();
        repeat (2) add_sample(1'b0);                      // idle slots sit on the first table step
        add_write(0, 0, 20'h12345, SINE, 0, 0, 1'b1);
        repeat (16) add_sample(1'b0);                     // long enough to wrap the accumulator
        for (int w = 0; w < 8; w++) begin
            add_write(w / 4, w % 4, 20'h06C4B + w * 20'h01357, wave_sel_e'(w), 0, 0, 1'b1);
        end
        repeat (20) add_sample(1'b0);                     // every wave reaches its negative half
        add_write(0, 0, 20'h06C4B, SINE, 0, 0, 1'b1);     // restart from phase zero
        repeat (3) add_sample(1'b0);
        for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
            for (int s = 0; s < `OPL_OPS_PER_BANK; s++) begin
                add_write(b, s, $random(seed) & PH_MASK, wave_sel_e'($random(seed) & 7),
                          $random(seed) & 15, $random(seed) & 7, 1'b0);
            end
        end
        repeat (8) add_sample(1'b0);
        for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
            for (int s = 0; s < `OPL_OPS_PER_BANK; s++) begin
                add_write(b, s, 20'h80000, SQUARE, 0, 0, 1'b1);   // full scale, alternating sign
            end
        end
        repeat (3) add_sample(1'b0);
        repeat (3) add_sample(1'b1);
    endfunction

    task automatic run_write(input row_t r);
        cfg    = r.wr;
        cfg_wr = 1'b1;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic run_sample(input row_t r, input int index);
        int cycles;
        int pulses;
        sample_en = 1'b1;                                 // taken on the next rising edge
        for (cycles = 1; cycles <= 2 * LATENCY; cycles++) begin
            @(negedge clk);
            sample_en = r.extra_strobe && (cycles == 2);  // lands while the sweep is busy
            if (sample_valid) begin
                break;
            end
        end
        check_count(cycles, LATENCY, $sformatf("row %0d sample_valid delay", index));
        check_sample(sample, r.expected, $sformatf("row %0d sample", index));
        pulses = 0;
        repeat (QUIET) begin
            @(negedge clk);
            if (sample_valid) begin
                pulses++;
            end
        end
        check_count(pulses, 0, $sformatf("row %0d extra sample_valid pulses", index));
    endtask

    initial begin
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg       = '0;
        sample_en = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (3) @(negedge clk);                        // three rising edges in reset
        rst_n = 1'b1;
        @(negedge clk);
        foreach (rows[i]) begin
            if (rows[i].is_sample) begin
                run_sample(rows[i], i);
            end else begin
                run_write(rows[i]);
            end
        end
        $display("test passed");
        $finish;
    end

    // a sample row takes about 10 cycles, a write row one
    initial begin
        int limit;
        wait (table_built);
        limit = rows.size() * 12 + 40;
        repeat (limit) @(posedge clk);
        $display("simulation hung: no verdict after %0d clock cycles", limit);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
